//--- include/trs_io_defs.svh
`ifndef TRS_IO_DEFS_SVH
`define TRS_IO_DEFS_SVH

// identity and version replies
`define TRS_IO_COOKIE   8'haf
`define TRS_IO_VERSION  {3'd0, 5'd3}    // major, minor

// io port served by the microcontroller
`define TRS_IO_PORT     8'd31

// shared memory, mapped to the upper 32K of the bus
`define RAM_ADDR_W      15

// breakpoint table
`define NUM_BP          8
`define BP_IDX_W        3

`define ESP_REQ_CYCLES  6'd50           // req pulse length in clocks
`define SYNC_STAGES     2               // flops on every async input

`endif

//--- verilog/trs_io_pkg.sv
package trs_io_pkg;

  // command codes from the microcontroller
  typedef enum logic [7:0] {
    cmd_get_cookie          = 8'd0,
    cmd_bram_poke           = 8'd1,
    cmd_bram_peek           = 8'd2,
    cmd_data_ready          = 8'd5,
    cmd_set_breakpoint      = 8'd6,
    cmd_clear_breakpoint    = 8'd7,
    cmd_enable_breakpoints  = 8'd11,
    cmd_disable_breakpoints = 8'd12,
    cmd_bp_resume           = 8'd13,
    cmd_get_version         = 8'd15
  } cmd_e;

  // pending port access as shown to the microcontroller
  typedef enum logic [3:0] {
    esp_trs_io_in  = 4'd0,
    esp_trs_io_out = 4'd1,
    esp_none       = 4'd15
  } esp_status_e;

  typedef struct packed {
    logic [7:0] addr_lo;   // first byte after the command
    logic [7:0] addr_hi;
    logic [7:0] data;      // poke only
  } mem_param_t;

  typedef struct packed {
    logic [7:0] slot;
    logic [7:0] addr_lo;
    logic [7:0] addr_hi;
  } bp_param_t;

  // same three bytes, read per command
  typedef union packed {
    mem_param_t mem;
    bp_param_t  bp;
  } param_u;

  typedef enum logic [1:0] {
    st_idle,
    st_read_params
  } parser_state_e;

endpackage

//--- verilog/spi_byte_link.sv
`timescale 1ns/10ps
`include "trs_io_defs.svh"

module spi_byte_link (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       sclk,
  input  logic       cs_n,
  input  logic       mosi,
  output logic       miso,
  output logic [7:0] rx_byte,
  output logic       rx_valid,
  input  logic [7:0] tx_byte,
  input  logic       tx_arm,
  output logic       reply_pending
);

  logic [`SYNC_STAGES:0]   sclk_sync;   // extra flop for edge detect
  logic [`SYNC_STAGES-1:0] cs_sync;
  logic [`SYNC_STAGES-1:0] mosi_sync;
  logic [2:0]              bit_cnt;
  logic [7:0]              rx_sh;
  logic [7:0]              tx_sh;
  logic                    load_pend;   // reply armed, not yet in tx_sh
  logic                    cs_active;
  logic                    sclk_rise;
  logic                    sclk_fall;
  logic                    byte_done;

  assign cs_active = ~cs_sync[`SYNC_STAGES-1];
  assign sclk_rise = cs_active && (sclk_sync[`SYNC_STAGES:`SYNC_STAGES-1] == 2'b01);
  assign sclk_fall = cs_active && (sclk_sync[`SYNC_STAGES:`SYNC_STAGES-1] == 2'b10);
  assign byte_done = sclk_rise && (bit_cnt == 3'd7);

  assign rx_byte = rx_sh;
  assign miso    = ~cs_n & tx_sh[7];    // low while deselected

  // msb first, sampled with the same delay as sclk
  always_ff @(posedge clk) begin
    if (sclk_rise)
      rx_sh <= {rx_sh[6:0], mosi_sync[`SYNC_STAGES-1]};
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sclk_sync     <= '0;
      cs_sync       <= '1;
      mosi_sync     <= '0;
      bit_cnt       <= 3'd0;
      rx_valid      <= 1'b0;
      reply_pending <= 1'b0;
      load_pend     <= 1'b0;
      tx_sh         <= 8'h00;
    end else begin
      sclk_sync <= {sclk_sync[`SYNC_STAGES-1:0], sclk};
      cs_sync   <= {cs_sync[`SYNC_STAGES-2:0], cs_n};
      mosi_sync <= {mosi_sync[`SYNC_STAGES-2:0], mosi};
      if (!cs_active)
        bit_cnt <= 3'd0;
      else if (sclk_rise)
        bit_cnt <= bit_cnt + 3'd1;
      rx_valid <= byte_done && !reply_pending;   // reply slot never reaches the parser
      if (tx_arm)
        reply_pending <= 1'b1;
      else if (byte_done)
        reply_pending <= 1'b0;                   // reply slot clocked out
      // first falling edge after arming loads the byte, later ones shift
      if (sclk_fall && load_pend) begin
        tx_sh     <= tx_byte;
        load_pend <= 1'b0;
      end else if (sclk_fall) begin
        tx_sh <= {tx_sh[6:0], 1'b0};
      end
      if (tx_arm)
        load_pend <= 1'b1;
    end
  end

endmodule

//--- verilog/cmd_parser.sv
`timescale 1ns/10ps
`include "trs_io_defs.svh"

module cmd_parser
  import trs_io_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic [7:0] rx_byte,
  input  logic       rx_valid,
  output logic [7:0] tx_byte,
  output logic       tx_arm,
  output logic       act,
  output cmd_e       cmd,
  output param_u     params,
  input  logic [7:0] ram_host_rdata,
  input  logic       ram_host_rvalid
);

  parser_state_e state;
  logic [1:0]    remaining;   // parameter bytes still expected
  logic [1:0]    idx;         // next parameter slot
  cmd_e          rx_cmd;

  assign rx_cmd = cmd_e'(rx_byte);

  // parameter bytes fill the union from the top byte down
  always_ff @(posedge clk) begin
    if (rx_valid && state == st_read_params) begin
      case (idx)
        2'd0:    params[23:16] <= rx_byte;
        2'd1:    params[15:8]  <= rx_byte;
        default: params[7:0]   <= rx_byte;
      endcase
    end
  end

  // reply byte, constant or peek result
  always_ff @(posedge clk) begin
    if (ram_host_rvalid)
      tx_byte <= ram_host_rdata;
    else if (rx_valid && state == st_idle && rx_cmd == cmd_get_cookie)
      tx_byte <= `TRS_IO_COOKIE;
    else if (rx_valid && state == st_idle && rx_cmd == cmd_get_version)
      tx_byte <= `TRS_IO_VERSION;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= st_idle;
      remaining <= 2'd0;
      idx       <= 2'd0;
      cmd       <= cmd_get_cookie;
      act       <= 1'b0;
      tx_arm    <= 1'b0;
    end else begin
      act    <= 1'b0;
      tx_arm <= ram_host_rvalid;   // peek data is back
      if (rx_valid) begin
        case (state)
          st_idle: begin
            idx <= 2'd0;
            case (rx_cmd)
              cmd_get_cookie, cmd_get_version: begin
                cmd    <= rx_cmd;
                act    <= 1'b1;
                tx_arm <= 1'b1;
              end
              cmd_data_ready, cmd_enable_breakpoints,
              cmd_disable_breakpoints, cmd_bp_resume: begin
                cmd <= rx_cmd;
                act <= 1'b1;      // no parameters
              end
              cmd_bram_poke, cmd_set_breakpoint: begin
                cmd       <= rx_cmd;
                remaining <= 2'd3;
                state     <= st_read_params;
              end
              cmd_bram_peek: begin
                cmd       <= rx_cmd;
                remaining <= 2'd2;
                state     <= st_read_params;
              end
              cmd_clear_breakpoint: begin
                cmd       <= rx_cmd;
                remaining <= 2'd1;
                state     <= st_read_params;
              end
              default: ;          // unknown code, dropped
            endcase
          end
          default: begin
            idx <= idx + 2'd1;
            if (remaining == 2'd1) begin
              act   <= 1'b1;      // last parameter in
              state <= st_idle;
            end else begin
              remaining <= remaining - 2'd1;
            end
          end
        endcase
      end
    end
  end

endmodule

//--- verilog/esp_req_timer.sv
`timescale 1ns/10ps
`include "trs_io_defs.svh"

module esp_req_timer
  import trs_io_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic io_edge,
  input  logic io_port_hit,
  input  logic done,
  input  logic act,
  input  cmd_e cmd,
  output logic req,
  output logic wait_out,
  output logic int_n
);

  logic [`SYNC_STAGES:0] done_sync;
  logic [5:0]            count;     // req clocks left
  logic                  start;
  logic                  done_rise;

  assign start     = io_edge && io_port_hit;
  assign done_rise = (done_sync[`SYNC_STAGES:`SYNC_STAGES-1] == 2'b01);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      done_sync <= '0;
      count     <= 6'd0;
      req       <= 1'b0;
      wait_out  <= 1'b0;
      int_n     <= 1'b1;
    end else begin
      done_sync <= {done_sync[`SYNC_STAGES-1:0], done};
      if (start) begin
        req      <= 1'b1;              // restarts if still running
        count    <= `ESP_REQ_CYCLES;
        wait_out <= 1'b1;
      end else begin
        if (count == 6'd1)
          req <= 1'b0;
        if (count != 6'd0)
          count <= count - 6'd1;
        if (done_rise)
          wait_out <= 1'b0;            // microcontroller finished
      end
      if (start)
        int_n <= 1'b1;                 // port access acknowledges the irq
      if (act && cmd == cmd_data_ready)
        int_n <= 1'b0;
    end
  end

endmodule

//--- verilog/bus_decode.sv
`timescale 1ns/10ps
`include "trs_io_defs.svh"

module bus_decode
  import trs_io_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic [15:0] bus_addr,
  input  logic        bus_rd_n,
  input  logic        bus_wr_n,
  input  logic        bus_in_n,
  input  logic        bus_out_n,
  output logic        mem_rd_edge,
  output logic        mem_wr_edge,
  output logic        io_edge,
  output logic        io_port_hit,
  output esp_status_e esp_status
);

  // strobe bits, active high: 0 rd, 1 wr, 2 in, 3 out
  logic [`SYNC_STAGES:0][3:0] strb_sync;
  logic [3:0]                 strb_raw;
  logic [3:0]                 strb_now;
  logic [3:0]                 strb_rise;
  logic                       port_match;

  assign strb_raw   = ~{bus_out_n, bus_in_n, bus_wr_n, bus_rd_n};
  assign strb_now   = strb_sync[`SYNC_STAGES-1];
  assign strb_rise  = strb_now & ~strb_sync[`SYNC_STAGES];
  assign port_match = (bus_addr[7:0] == `TRS_IO_PORT);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      strb_sync   <= '0;
      mem_rd_edge <= 1'b0;
      mem_wr_edge <= 1'b0;
      io_edge     <= 1'b0;
      io_port_hit <= 1'b0;
      esp_status  <= esp_none;
    end else begin
      strb_sync   <= {strb_sync[`SYNC_STAGES-1:0], strb_raw};
      mem_rd_edge <= strb_rise[0] && bus_addr[15];   // upper 32K only
      mem_wr_edge <= strb_rise[1] && bus_addr[15];
      io_edge     <= |strb_rise[3:2];
      io_port_hit <= port_match && (|strb_now[3:2]);
      if (port_match && strb_now[2])
        esp_status <= esp_trs_io_in;
      else if (port_match && strb_now[3])
        esp_status <= esp_trs_io_out;
      else
        esp_status <= esp_none;
    end
  end

endmodule

//--- verilog/breakpoint_unit.sv
`timescale 1ns/10ps
`include "trs_io_defs.svh"

module breakpoint_unit
  import trs_io_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 act,
  input  cmd_e                 cmd,
  input  param_u               params,
  input  logic [15:0]          bus_addr,
  input  logic                 mem_rd_edge,
  output logic                 bp_halt,
  output logic [`BP_IDX_W-1:0] bp_slot
);

  logic [15:0]          bp_addr [`NUM_BP];
  logic [`NUM_BP-1:0]   bp_active;
  logic                 bp_en;       // global enable
  logic                 hit;
  logic [`BP_IDX_W-1:0] hit_idx;
  logic [`BP_IDX_W-1:0] set_idx;

  assign set_idx = params.bp.slot[`BP_IDX_W-1:0];

  // lowest active slot wins, so scan downwards
  always_comb begin
    hit     = 1'b0;
    hit_idx = '0;
    for (int i = `NUM_BP - 1; i >= 0; i--) begin
      if (bp_active[i] && bp_addr[i] == bus_addr) begin
        hit     = 1'b1;
        hit_idx = `BP_IDX_W'(i);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (act && cmd == cmd_set_breakpoint)
      bp_addr[set_idx] <= {params.bp.addr_hi, params.bp.addr_lo};
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bp_active <= '0;
      bp_en     <= 1'b0;
      bp_halt   <= 1'b0;
      bp_slot   <= '0;
    end else begin
      if (act) begin
        case (cmd)
          cmd_set_breakpoint:      bp_active[set_idx] <= 1'b1;
          cmd_clear_breakpoint:    bp_active[set_idx] <= 1'b0;
          cmd_enable_breakpoints:  bp_en <= 1'b1;
          cmd_disable_breakpoints: bp_en <= 1'b0;
          cmd_bp_resume:           bp_halt <= 1'b0;
          default: ;
        endcase
      end
      // only while running, slot stays until resume
      if (mem_rd_edge && bp_en && hit && !bp_halt) begin
        bp_halt <= 1'b1;
        bp_slot <= hit_idx;
      end
    end
  end

endmodule

//--- verilog/shared_ram.sv
`timescale 1ns/10ps
`include "trs_io_defs.svh"

module shared_ram
  import trs_io_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        act,
  input  cmd_e        cmd,
  input  param_u      params,
  output logic [7:0]  ram_host_rdata,
  output logic        ram_host_rvalid,
  input  logic [15:0] bus_addr,
  input  logic [7:0]  bus_din,
  input  logic        mem_rd_edge,
  input  logic        mem_wr_edge,
  input  logic        bus_rd_n,
  output logic [7:0]  bus_dout,
  output logic        bus_data_oe
);

  logic [7:0]              mem [1 << `RAM_ADDR_W];
  logic [`RAM_ADDR_W-1:0]  host_addr;
  logic [`RAM_ADDR_W-1:0]  bus_ram_addr;   // a15 dropped, window already decoded
  logic [7:0]              host_q;
  logic [7:0]              bus_q;
  logic                    host_rd;
  logic                    host_wr;
  logic                    host_q_valid;
  logic                    bus_q_valid;
  logic [`SYNC_STAGES-1:0] rd_n_sync;

  assign host_addr    = `RAM_ADDR_W'({params.mem.addr_hi, params.mem.addr_lo});
  assign bus_ram_addr = bus_addr[`RAM_ADDR_W-1:0];
  assign host_wr      = act && cmd == cmd_bram_poke;
  assign host_rd      = act && cmd == cmd_bram_peek;

  // array read, then output register on each port
  always_ff @(posedge clk) begin
    if (host_wr)
      mem[host_addr] <= params.mem.data;
    if (mem_wr_edge)
      mem[bus_ram_addr] <= bus_din;          // bus wins a same-address collision
    if (host_rd)
      host_q <= mem[host_addr];
    if (mem_rd_edge)
      bus_q <= mem[bus_ram_addr];
    if (host_q_valid)
      ram_host_rdata <= host_q;
    if (bus_q_valid)
      bus_dout <= bus_q;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      host_q_valid    <= 1'b0;
      ram_host_rvalid <= 1'b0;
      bus_q_valid     <= 1'b0;
      bus_data_oe     <= 1'b0;
      rd_n_sync       <= '1;
    end else begin
      rd_n_sync       <= {rd_n_sync[`SYNC_STAGES-2:0], bus_rd_n};
      host_q_valid    <= host_rd;
      ram_host_rvalid <= host_q_valid;
      bus_q_valid     <= mem_rd_edge;
      if (bus_q_valid)
        bus_data_oe <= 1'b1;
      else if (rd_n_sync[`SYNC_STAGES-1])
        bus_data_oe <= 1'b0;               // read strobe released
    end
  end

endmodule

//--- verilog/trs_io_top.sv
`timescale 1ns/10ps
`include "trs_io_defs.svh"

module trs_io_top
  import trs_io_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 sclk,
  input  logic                 cs_n,
  input  logic                 mosi,
  output logic                 miso,
  input  logic                 done,
  output logic                 req,
  output esp_status_e          esp_status,
  input  logic [15:0]          bus_addr,
  input  logic [7:0]           bus_din,
  input  logic                 bus_rd_n,
  input  logic                 bus_wr_n,
  input  logic                 bus_in_n,
  input  logic                 bus_out_n,
  output logic [7:0]           bus_dout,
  output logic                 bus_data_oe,
  output logic                 wait_out,
  output logic                 int_n,
  output logic                 bp_halt,
  output logic [`BP_IDX_W-1:0] bp_slot
);

  // spi link to parser
  logic [7:0] rx_byte;
  logic       rx_valid;
  logic [7:0] tx_byte;
  logic       tx_arm;

  // parser actions
  logic       act;
  cmd_e       cmd;
  param_u     params;
  logic [7:0] ram_host_rdata;
  logic       ram_host_rvalid;

  // bus side strobes
  logic       mem_rd_edge;
  logic       mem_wr_edge;
  logic       io_edge;
  logic       io_port_hit;

  // all port names match the nets above
  spi_byte_link   u_spi   (.*, .reply_pending());   // pending flag stays inside the link
  cmd_parser      u_parse (.*);
  esp_req_timer   u_req   (.*);
  bus_decode      u_dec   (.*);
  breakpoint_unit u_bp    (.*);
  shared_ram      u_ram   (.*);

endmodule

//--- tests/trs_io_properties.sv
`timescale 1ns/10ps
`include "trs_io_defs.svh"

module trs_io_properties (
  input logic clk,
  input logic rst_n,
  input logic req,
  input logic wait_out,
  input logic done,
  input logic bp_halt,
  input logic mem_rd_edge
);

  logic [6:0] req_run;          // clocks req has been high so far
  logic       done_seen;        // done sampled since wait went up
  int         fail_count = 0;   // failed assertions so far

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_run   <= 7'd0;
      done_seen <= 1'b0;
    end else begin
      req_run   <= req ? req_run + 7'd1 : 7'd0;
      done_seen <= done || (done_seen && wait_out);   // sticky while wait held
    end
  end

  req_max_len: assert property (@(posedge clk) disable iff (!rst_n)
    req_run <= 7'(`ESP_REQ_CYCLES))
    else begin
      fail_count++;
      $error("req held longer than the request pulse");
    end

  // halt only ever follows a bus memory read
  halt_after_read: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(bp_halt) |-> $past(mem_rd_edge))
    else begin
      fail_count++;
      $error("bp_halt rose without a memory read edge");
    end

  wait_after_done: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(wait_out) |-> done_seen)
    else begin
      fail_count++;
      $error("wait_out dropped before done");
    end

endmodule

bind trs_io_top trs_io_properties u_props (
  .clk         (clk),
  .rst_n       (rst_n),
  .req         (req),
  .wait_out    (wait_out),
  .done        (done),
  .bp_halt     (bp_halt),
  .mem_rd_edge (mem_rd_edge)
);

//--- tests/tb_trs_io.sv
`timescale 1ns/10ps
`include "trs_io_defs.svh"

module tb_trs_io
  import trs_io_pkg::*;
();

  localparam int sel_req  = 0;
  localparam int sel_wait = 1;
  localparam int sel_oe   = 2;

  logic                 clk;
  logic                 rst_n;
  logic                 sclk;
  logic                 cs_n;
  logic                 mosi;
  logic                 miso;
  logic                 done;
  logic                 req;
  esp_status_e          esp_status;
  logic [15:0]          bus_addr;
  logic [7:0]           bus_din;
  logic                 bus_rd_n;
  logic                 bus_wr_n;
  logic                 bus_in_n;
  logic                 bus_out_n;
  logic [7:0]           bus_dout;
  logic                 bus_data_oe;
  logic                 wait_out;
  logic                 int_n;
  logic                 bp_halt;
  logic [`BP_IDX_W-1:0] bp_slot;

  int          errors;
  int          checks;
  int          test_errs;     // errors in the running test
  int          cycles;
  int          cycle_limit = 2000;   // grows with every pattern line
  logic [31:0] lfsr;
  logic [7:0]  ram_model [logic [14:0]];   // host view of the shared memory
  logic [14:0] sweep_addr [$];
  logic [7:0]  op_q [$];
  logic [15:0] addr_q [$];
  logic [7:0]  data_q [$];
  logic [7:0]  exp_q [$];

  trs_io_top u_dut (.*);

  always #10 clk = ~clk;

  task automatic record_error(input string msg);
    errors++;
    test_errs++;
    $display("%s", msg);
  endtask

  task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
    checks++;
    if (got !== exp)
      record_error($sformatf("FAIL %0t: %s got %h expected %h", $time, what, got, exp));
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp)
      record_error($sformatf("FAIL %0t: %s got %b expected %b", $time, what, got, exp));
  endtask

  task automatic check_status(input esp_status_e got, input esp_status_e exp,
                              input string what);
    checks++;
    if (got !== exp)
      record_error($sformatf("FAIL %0t: %s got %s expected %s", $time, what,
                             got.name(), exp.name()));
  endtask

  // galois form shifting right
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    lfsr_step = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [15:0] v);
    v = 16'h0000;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v    = {v[14:0], lfsr[0]};   // one step per bit
    end
  endtask

  function automatic logic probe(input int sel);
    case (sel)
      sel_req:  probe = req;
      sel_wait: probe = wait_out;
      default:  probe = bus_data_oe;
    endcase
  endfunction

  task automatic wait_for_level(input int sel, input logic level, input int limit,
                                input string what);
    int n;
    n = 0;
    while (probe(sel) !== level && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (probe(sel) !== level)
      record_error($sformatf("timeout at %0t: %s did not happen within %0d cycles",
                             $time, what, limit));
  endtask

  // mode 0 master at 8 clocks per half bit
  task automatic spi_byte(input logic [7:0] tx, output logic [7:0] rx);
    for (int i = 7; i >= 0; i--) begin
      mosi = tx[i];
      repeat (8) @(negedge clk);
      rx[i] = miso;          // settled since the last falling sclk
      sclk  = 1'b1;
      repeat (8) @(negedge clk);
      sclk  = 1'b0;
    end
  endtask

  // bytes go out msb byte first and the last one brings back the reply
  task automatic spi_frame(input logic [31:0] bytes, input int n, output logic [7:0] last_rx);
    logic [7:0] rx;
    rx   = 8'h00;
    cs_n = 1'b0;
    repeat (4) @(negedge clk);
    for (int k = 0; k < n; k++)
      spi_byte(bytes[31 - 8*k -: 8], rx);
    cs_n = 1'b1;
    repeat (8) @(negedge clk);   // action long done by now
    last_rx = rx;
  endtask

  task automatic bus_read(input logic [15:0] addr, output logic [7:0] data);
    bus_addr = addr;
    bus_rd_n = 1'b0;
    wait_for_level(sel_oe, 1'b1, 12, "bus_data_oe rise");
    data = bus_dout;
    repeat (3) @(negedge clk);   // strobe still held
    check_bit(bus_data_oe, 1'b1, "bus_data_oe held during read");
    bus_rd_n = 1'b1;
    wait_for_level(sel_oe, 1'b0, 12, "bus_data_oe release");
    repeat (2) @(negedge clk);   // let the strobe sync clear
  endtask

  task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
    bus_addr = addr;
    bus_din  = data;
    bus_wr_n = 1'b0;
    repeat (6) @(negedge clk);   // write edge lands 3 clocks in
    bus_wr_n = 1'b1;
    repeat (4) @(negedge clk);
  endtask

  task automatic port_access(input logic [15:0] addr, input logic is_out,
                             input esp_status_e exp);
    int width;
    bus_addr = addr;
    if (is_out)
      bus_out_n = 1'b0;
    else
      bus_in_n = 1'b0;
    if (exp == esp_none) begin
      repeat (8) @(negedge clk);
      check_status(esp_status, exp, "status on other port");
      check_bit(req, 1'b0, "req on other port");
    end else begin
      wait_for_level(sel_req, 1'b1, 12, "req rise");
      check_status(esp_status, exp, "status during access");
      check_bit(int_n, 1'b1, "irq after port access");
      width = 0;
      while (req && width < 200) begin
        @(negedge clk);
        width++;
      end
      check_byte(8'(width), 8'd50, "req pulse width");   // 50 clocks
      check_bit(wait_out, 1'b1, "wait held after req");
    end
    bus_in_n  = 1'b1;
    bus_out_n = 1'b1;
    repeat (4) @(negedge clk);
    check_status(esp_status, esp_none, "status after access");
    if (exp != esp_none) begin
      done = 1'b1;                                        // microcontroller finished
      wait_for_level(sel_wait, 1'b0, 12, "wait_out release");
      done = 1'b0;
    end
    repeat (4) @(negedge clk);
  endtask

  task automatic lfsr_sweep(input int n);
    logic [15:0] r;
    logic [14:0] a;
    logic [7:0]  d;
    logic [7:0]  rx;
    sweep_addr.delete();
    for (int k = 0; k < n; k++) begin
      take_bits(15, r);
      a = r[14:0];
      take_bits(8, r);
      d = r[7:0];
      spi_frame({cmd_bram_poke, a[7:0], 1'b0, a[14:8], d}, 4, rx);
      ram_model[a] = d;
      sweep_addr.push_back(a);
    end
    foreach (sweep_addr[k]) begin
      a = sweep_addr[k];
      spi_frame({cmd_bram_peek, a[7:0], 1'b0, a[14:8], 8'h00}, 4, rx);
      check_byte(rx, ram_model[a], "sweep peek");
    end
  endtask

  task automatic run_op(input logic [7:0] op, input logic [15:0] addr,
                        input logic [7:0] data, input logic [7:0] exp);
    logic [7:0] rx;
    case (op)
      8'h00: begin
        spi_frame({cmd_get_cookie, 24'h0}, 2, rx);   // cmd plus reply slot
        check_byte(rx, exp, "cookie reply");
      end
      8'h01: begin
        spi_frame({cmd_get_version, 24'h0}, 2, rx);
        check_byte(rx, exp, "version reply");
      end
      8'h02: begin
        spi_frame({cmd_bram_poke, addr[7:0], addr[15:8], data}, 4, rx);
        ram_model[addr[14:0]] = data;
      end
      8'h03: begin
        spi_frame({cmd_bram_peek, addr[7:0], addr[15:8], 8'h00}, 4, rx);
        check_byte(rx, exp, "peek reply");
      end
      8'h04: begin
        bus_read(addr, rx);
        check_byte(rx, exp, "bus read data");
      end
      8'h05: begin
        bus_write(addr, data);
        ram_model[addr[14:0]] = data;   // upper window with a15 dropped
      end
      8'h06: spi_frame({cmd_set_breakpoint, data, addr[7:0], addr[15:8]}, 4, rx);
      8'h07: spi_frame({cmd_clear_breakpoint, data, 16'h0}, 2, rx);
      8'h08: spi_frame({cmd_enable_breakpoints, 24'h0}, 1, rx);
      8'h09: spi_frame({cmd_disable_breakpoints, 24'h0}, 1, rx);
      8'h0a: begin
        bus_read(addr, rx);
        if (exp == 8'hff) begin
          check_bit(bp_halt, 1'b0, "bp_halt with no live breakpoint");
        end else begin
          check_bit(bp_halt, 1'b1, "bp_halt on match");
          check_byte(8'(bp_slot), exp, "halt slot");
        end
      end
      8'h0b: begin
        spi_frame({cmd_bp_resume, 24'h0}, 1, rx);
        check_bit(bp_halt, 1'b0, "bp_halt after resume");
      end
      8'h0c: port_access(addr, data[0], esp_status_e'(exp[3:0]));
      8'h0d: begin
        spi_frame({cmd_data_ready, 24'h0}, 1, rx);
        check_bit(int_n, 1'b0, "irq after data ready");
      end
      8'h0e: lfsr_sweep(int'(data));
      default: record_error($sformatf("pattern line has an unknown op code %h", op));
    endcase
  endtask

  // stops a run that never reaches the report
  initial begin : watchdog
    cycles = 0;
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("run stopped after %0d cycles before all patterns were done", cycles);
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin : main
    int          fd;
    int          nf;
    string       line;
    logic [7:0]  op_v;
    logic [15:0] addr_v;
    logic [7:0]  data_v;
    logic [7:0]  exp_v;
    clk       = 1'b0;
    rst_n     = 1'b0;
    sclk      = 1'b0;
    cs_n      = 1'b1;
    mosi      = 1'b0;
    done      = 1'b0;
    bus_addr  = 16'h0000;
    bus_din   = 8'h00;
    bus_rd_n  = 1'b1;
    bus_wr_n  = 1'b1;
    bus_in_n  = 1'b1;
    bus_out_n = 1'b1;
    errors    = 0;
    checks    = 0;
    test_errs = 0;
    lfsr      = 32'h2e0;
    fd = $fopen("tests/trs_io_patterns.txt", "r");
    if (fd == 0) begin
      record_error("could not open the pattern file tests/trs_io_patterns.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 0 && line.substr(0, 0) != "#") begin
          nf = $sscanf(line, "%h %h %h %h", op_v, addr_v, data_v, exp_v);
          if (nf == 4) begin
            op_q.push_back(op_v);
            addr_q.push_back(addr_v);
            data_q.push_back(data_v);
            exp_q.push_back(exp_v);
            cycle_limit += 700;                          // 4 spi bytes worst case
            if (op_v == 8'h0e)
              cycle_limit += int'(data_v) * 1400;        // poke and peek per entry
          end
        end
      end
      $fclose(fd);
    end
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    repeat (4) @(negedge clk);
    for (int t = 0; t < op_q.size(); t++) begin
      test_errs = 0;
      run_op(op_q[t], addr_q[t], data_q[t], exp_q[t]);
      $display("test %0d op %h addr %h: %s", t, op_q[t], addr_q[t],
               (test_errs == 0) ? "passed" : "failed");
    end
    errors += u_dut.u_props.fail_count;   // bound assertion failures
    $display("tests %0d, checks %0d, errors %0d", op_q.size(), checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- src.f
+incdir+include
verilog/trs_io_pkg.sv
verilog/spi_byte_link.sv
verilog/cmd_parser.sv
verilog/esp_req_timer.sv
verilog/bus_decode.sv
verilog/breakpoint_unit.sv
verilog/shared_ram.sv
verilog/trs_io_top.sv
tests/trs_io_properties.sv
tests/tb_trs_io.sv

//--- Makefile
# verilator build and run for the trs io core
VERILATOR ?= verilator
TOP       ?= tb_trs_io
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= NO ERRORS

SRCS := $(shell grep -v '^+' $(FILELIST)) include/trs_io_defs.svh
EXE  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(EXE)

$(EXE): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(EXE)
	./$(EXE) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tests/trs_io_patterns.txt
# columns: op addr data expect, all hex, unused fields 0
# ops 0 cookie 1 version 2 poke 3 peek 4 bus rd 5 bus wr 6 set bp (data slot) 7 clr bp 8 bp on 9 off
# a bp read (expect slot, ff none) b resume c port (data 0 in 1 out, expect status) d irq e sweep
0 0000 00 af
1 0000 00 03
2 0123 5a 00
2 7ffe c3 00
3 0123 00 5a
3 7ffe 00 c3
4 8123 00 5a
4 fffe 00 c3
5 8456 99 00
3 0456 00 99
6 9000 02 00
6 9000 05 00
8 0000 00 00
a 9000 00 02
b 0000 00 00
7 0000 02 00
a 9000 00 05
b 0000 00 00
7 0000 05 00
a 9000 00 ff
6 a5a0 01 00
9 0000 00 00
a a5a0 00 ff
c 001f 00 00
c 001f 01 01
c 0030 00 0f
d 0000 00 00
c 001f 01 01
e 0000 10 00
0 0000 00 af
